//--- hdl/csrPkg.sv
package csrPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Register width, fixed so the structs below have a known size
  localparam int XLEN = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Supervisor CSR addresses
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [11:0] AdrSstatus    = 12'h100;
  localparam logic [11:0] AdrSedeleg    = 12'h102;
  localparam logic [11:0] AdrSideleg    = 12'h103;
  localparam logic [11:0] AdrSie        = 12'h104;
  localparam logic [11:0] AdrStvec      = 12'h105;
  localparam logic [11:0] AdrScounteren = 12'h106;
  localparam logic [11:0] AdrSscratch   = 12'h140;
  localparam logic [11:0] AdrSepc       = 12'h141;
  localparam logic [11:0] AdrScause     = 12'h142;
  localparam logic [11:0] AdrStval      = 12'h143;
  localparam logic [11:0] AdrSip        = 12'h144;
  localparam logic [11:0] AdrSatp       = 12'h180;

  ////////////////////////////////////////////////////////////////////////////
  // Bit positions and write masks
  ////////////////////////////////////////////////////////////////////////////

  // sstatus fields touched by a trap
  localparam int StatusSieBit  = 1;
  localparam int StatusSpieBit = 5;
  localparam int StatusSppBit  = 8;

  // Supervisor software, timer and external interrupt bits in sie/sip
  localparam int IrqSsipBit = 1;
  localparam int IrqStipBit = 5;
  localparam int IrqSeipBit = 9;

  // SIE, SPIE, SPP, SUM and MXR
  localparam logic [XLEN-1:0] SstatusMask = 32'h000C_0122;
  // SSIE, STIE and SEIE
  localparam logic [11:0]     SieMask     = 12'h222;

  ////////////////////////////////////////////////////////////////////////////
  // Request and trap types
  ////////////////////////////////////////////////////////////////////////////

  // CSR instruction flavour, immediate forms already folded into src
  typedef enum logic [1:0] {
    CsrNone = 2'd0,
    CsrRw   = 2'd1,
    CsrRs   = 2'd2,
    CsrRc   = 2'd3
  } csrOpE;

  // One CSR instruction per cycle
  typedef struct packed {
    logic            valid;
    csrOpE           op;
    logic [11:0]     adr;
    logic [XLEN-1:0] src;
  } csrReqT;

  // Trap into S-mode
  typedef struct packed {
    logic            strobe;
    logic [XLEN-1:0] epc;
    logic [XLEN-1:0] cause;
    logic [XLEN-1:0] tval;
    // Set when the trapped instruction ran in S-mode
    logic            prevPrivS;
  } trapT;

endpackage

//--- hdl/csrSupervisorUnit.sv
`timescale 1ns/1ns

module csrSupervisorUnit import csrPkg::*; #(
  parameter int NSupported = 1
) (
  input  logic            clk,
  input  logic            rstN,
  input  csrReqT          csrReq,
  input  trapT            trap,
  input  logic [2:0]      pendIrq,
  output logic [XLEN-1:0] readVal,
  output logic            illegal,
  output logic [XLEN-1:0] stvec,
  output logic [XLEN-1:0] sepc,
  output logic [XLEN-1:0] sedeleg,
  output logic [XLEN-1:0] sideleg,
  output logic [XLEN-1:0] sstatus,
  output logic            pendingIrq
);

  // Write path
  logic [XLEN-1:0] wrVal;
  logic            wrEn;
  // Per-block write strobes
  logic            statusWe;
  logic            sieWe;
  logic            sipWe;
  // Interrupt registers fed back to the read mux
  logic [11:0]     sie;
  logic [11:0]     sip;

  ////////////////////////////////////////////////////////////////////////////
  // Write value from old contents
  ////////////////////////////////////////////////////////////////////////////

  csrWriteValue i_csrWriteValue (
    .req     (csrReq),
    .oldVal  (readVal),
    .illegal (illegal),
    .wrVal   (wrVal),
    .wrEn    (wrEn)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Decode, register file and the two dedicated blocks
  ////////////////////////////////////////////////////////////////////////////

  supervisorCsrs #(
    .NSupported (NSupported)
  ) i_supervisorCsrs (
    .clk      (clk),
    .rstN     (rstN),
    .req      (csrReq),
    .trap     (trap),
    .wrVal    (wrVal),
    .wrEn     (wrEn),
    .sstatus  (sstatus),
    .sie      (sie),
    .sip      (sip),
    .readVal  (readVal),
    .illegal  (illegal),
    .statusWe (statusWe),
    .sieWe    (sieWe),
    .sipWe    (sipWe),
    .stvec    (stvec),
    .sepc     (sepc),
    .sedeleg  (sedeleg),
    .sideleg  (sideleg)
  );

  supervisorStatus i_supervisorStatus (
    .clk     (clk),
    .rstN    (rstN),
    .we      (statusWe),
    .wrVal   (wrVal),
    .trap    (trap),
    .sstatus (sstatus)
  );

  supervisorInterrupts i_supervisorInterrupts (
    .clk        (clk),
    .rstN       (rstN),
    .sieWe      (sieWe),
    .sipWe      (sipWe),
    .wrVal      (wrVal),
    .pendIrq    (pendIrq),
    .sie        (sie),
    .sip        (sip),
    .pendingIrq (pendingIrq)
  );

endmodule

//--- hdl/csrWriteValue.sv
`timescale 1ns/1ns

module csrWriteValue import csrPkg::*; (
  input  csrReqT          req,
  input  logic [XLEN-1:0] oldVal,
  input  logic            illegal,
  output logic [XLEN-1:0] wrVal,
  output logic            wrEn
);

  // Source is all zeros
  logic srcZero;

  assign srcZero = (req.src == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Read-modify-write value
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req.op)
      CsrRw:   wrVal = req.src;
      // Set bits named in src
      CsrRs:   wrVal = oldVal | req.src;
      // Clear bits named in src
      CsrRc:   wrVal = oldVal & ~req.src;
      // No write, keep old contents on the bus
      default: wrVal = oldVal;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write enable
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req.op)
      CsrRw:          wrEn = req.valid & ~illegal;
      // Set or clear with x0 / zero immediate writes nothing
      CsrRs, CsrRc:   wrEn = req.valid & ~illegal & ~srcZero;
      default:        wrEn = 1'b0;
    endcase
  end

endmodule

//--- hdl/supervisorCsrs.sv
`timescale 1ns/1ns

module supervisorCsrs import csrPkg::*; #(
  // User-level interrupts supported, enables the delegation registers
  parameter int NSupported = 1
) (
  input  logic            clk,
  input  logic            rstN,
  input  csrReqT          req,
  input  trapT            trap,
  input  logic [XLEN-1:0] wrVal,
  input  logic            wrEn,
  input  logic [XLEN-1:0] sstatus,
  input  logic [11:0]     sie,
  input  logic [11:0]     sip,
  output logic [XLEN-1:0] readVal,
  output logic            illegal,
  output logic            statusWe,
  output logic            sieWe,
  output logic            sipWe,
  output logic [XLEN-1:0] stvec,
  output logic [XLEN-1:0] sepc,
  output logic [XLEN-1:0] sedeleg,
  output logic [XLEN-1:0] sideleg
);

  // scounteren TM bit is hardwired to zero
  localparam logic [XLEN-1:0] ScounterenMask = ~(XLEN'(1) << 1);
  // sedeleg bits 11..9 are hardwired to zero
  localparam logic [XLEN-1:0] SedelegMask    = ~(XLEN'(3'b111) << 9);

  // Registers local to this block
  logic [XLEN-1:0] sscratch;
  logic [XLEN-1:0] scause;
  logic [XLEN-1:0] stval;
  logic [XLEN-1:0] satp;
  logic [XLEN-1:0] scounteren;

  // One-hot address selects
  logic selStatus, selSie, selSip;
  logic selStvec, selSscratch, selSepc, selScause;
  logic selStval, selSatp, selScounteren;
  logic selSedeleg, selSideleg;
  // Address maps onto an existing register
  logic known;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode and read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    selStatus     = 1'b0;
    selSie        = 1'b0;
    selSip        = 1'b0;
    selStvec      = 1'b0;
    selSscratch   = 1'b0;
    selSepc       = 1'b0;
    selScause     = 1'b0;
    selStval      = 1'b0;
    selSatp       = 1'b0;
    selScounteren = 1'b0;
    selSedeleg    = 1'b0;
    selSideleg    = 1'b0;
    known         = 1'b1;
    readVal       = '0;
    case (req.adr)
      AdrSstatus:    begin selStatus     = 1'b1; readVal = sstatus;    end
      AdrSie:        begin selSie        = 1'b1; readVal = XLEN'(sie); end
      AdrSip:        begin selSip        = 1'b1; readVal = XLEN'(sip); end
      AdrStvec:      begin selStvec      = 1'b1; readVal = stvec;      end
      AdrSscratch:   begin selSscratch   = 1'b1; readVal = sscratch;   end
      AdrSepc:       begin selSepc       = 1'b1; readVal = sepc;       end
      AdrScause:     begin selScause     = 1'b1; readVal = scause;     end
      AdrStval:      begin selStval      = 1'b1; readVal = stval;      end
      AdrSatp:       begin selSatp       = 1'b1; readVal = satp;       end
      AdrScounteren: begin selScounteren = 1'b1; readVal = scounteren; end
      // Delegation registers vanish without user-level interrupts
      AdrSedeleg: begin
        selSedeleg = (NSupported != 0);
        known      = (NSupported != 0);
        readVal    = sedeleg;
      end
      AdrSideleg: begin
        selSideleg = (NSupported != 0);
        known      = (NSupported != 0);
        readVal    = sideleg;
      end
      default: known = 1'b0;
    endcase
  end

  // Only a real request can be illegal
  assign illegal = req.valid & ~known;

  // Strobes to sstatus and interrupt blocks
  assign statusWe = wrEn & selStatus;
  assign sieWe    = wrEn & selSie;
  assign sipWe    = wrEn & selSip;

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stvec      <= '0;
      sscratch   <= '0;
      satp       <= '0;
      scounteren <= '0;
      sepc       <= '0;
      scause     <= '0;
      stval      <= '0;
    end else begin
      if (wrEn && selStvec)      stvec      <= wrVal;
      if (wrEn && selSscratch)   sscratch   <= wrVal;
      if (wrEn && selSatp)       satp       <= wrVal;
      if (wrEn && selScounteren) scounteren <= wrVal & ScounterenMask;
      // Trap state beats a CSR write in the same cycle
      if (trap.strobe) begin
        sepc   <= trap.epc;
        scause <= trap.cause;
        stval  <= trap.tval;
      end else begin
        if (wrEn && selSepc)   sepc   <= wrVal;
        if (wrEn && selScause) scause <= wrVal;
        if (wrEn && selStval)  stval  <= wrVal;
      end
    end
  end

  // Delegation registers
  if (NSupported != 0) begin : gDeleg
    always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
        sedeleg <= '0;
        sideleg <= '0;
      end else begin
        if (wrEn && selSedeleg) sedeleg <= wrVal & SedelegMask;
        if (wrEn && selSideleg) sideleg <= wrVal;
      end
    end
  end else begin : gNoDeleg
    assign sedeleg = '0;
    assign sideleg = '0;
  end

endmodule

//--- hdl/supervisorInterrupts.sv
`timescale 1ns/1ns

module supervisorInterrupts import csrPkg::*; (
  input  logic            clk,
  input  logic            rstN,
  input  logic            sieWe,
  input  logic            sipWe,
  input  logic [XLEN-1:0] wrVal,
  // External, timer, software
  input  logic [2:0]      pendIrq,
  output logic [11:0]     sie,
  output logic [11:0]     sip,
  output logic            pendingIrq
);

  // Software pending bit, the only writable part of sip
  logic ssip;

  ////////////////////////////////////////////////////////////////////////////
  // Enable and software-pending registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      sie  <= '0;
      ssip <= 1'b0;
    end else begin
      if (sieWe) sie  <= wrVal[11:0] & SieMask;
      if (sipWe) ssip <= wrVal[IrqSsipBit];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pending view
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sip = '0;
    // Stored bit or external software line
    sip[IrqSsipBit] = ssip | pendIrq[0];
    sip[IrqStipBit] = pendIrq[1];
    sip[IrqSeipBit] = pendIrq[2];
  end

  // Any enabled interrupt pending
  assign pendingIrq = |(sip & sie);

endmodule

//--- hdl/supervisorStatus.sv
`timescale 1ns/1ns

module supervisorStatus import csrPkg::*; (
  input  logic            clk,
  input  logic            rstN,
  input  logic            we,
  input  logic [XLEN-1:0] wrVal,
  input  trapT            trap,
  output logic [XLEN-1:0] sstatus
);

  // sstatus after a trap
  logic [XLEN-1:0] trapStatus;

  ////////////////////////////////////////////////////////////////////////////
  // Trap update
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    trapStatus = sstatus;
    // Remember the interrupt enable
    trapStatus[StatusSpieBit] = sstatus[StatusSieBit];
    // Interrupts off inside the handler
    trapStatus[StatusSieBit]  = 1'b0;
    // Previous privilege, S or U
    trapStatus[StatusSppBit]  = trap.prevPrivS;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      sstatus <= '0;
    end else if (trap.strobe) begin
      // Trap wins over a CSR write
      sstatus <= trapStatus;
    end else if (we) begin
      // Only SIE, SPIE, SPP, SUM and MXR stick
      sstatus <= wrVal & SstatusMask;
    end
  end

endmodule

//--- project.f
hdl/csrPkg.sv
hdl/csrWriteValue.sv
hdl/supervisorCsrs.sv
hdl/supervisorStatus.sv
hdl/supervisorInterrupts.sv
hdl/csrSupervisorUnit.sv
testbench/csrSupervisorUnit_props.sv
testbench/csrSupervisorUnitTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

LOG=sim.log

verilator --binary --timing --assert -f project.f \
  --top-module csrSupervisorUnitTb -o csrSupervisorUnitSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/csrSupervisorUnitSim > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  echo "Simulation FAILED, see $LOG"
  exit 1
fi

echo "Simulation passed"
exit 0

//--- testbench/csrSupervisorUnitTb.sv
`timescale 1ns/1ns

module csrSupervisorUnitTb import csrPkg::*; ();

  localparam int    ResetCycles = 10;
  localparam string StimFile    = "testbench/csr_stimulus.txt";

  // One stimulus line with its expected results
  typedef struct packed {
    csrReqT          req;
    trapT            trap;
    logic [2:0]      pendIrq;
    logic [XLEN-1:0] expRead;
    logic            expIllegal;
    logic            expPending;
  } vecT;

  logic            clk;
  logic            rstN;
  csrReqT          csrReq;
  trapT            trap;
  logic [2:0]      pendIrq;
  logic [XLEN-1:0] readVal;
  logic            illegal;
  logic [XLEN-1:0] stvec;
  logic [XLEN-1:0] sepc;
  logic [XLEN-1:0] sedeleg;
  logic [XLEN-1:0] sideleg;
  logic [XLEN-1:0] sstatus;
  logic            pendingIrq;

  vecT   vectors[$];
  string tags[$];
  bit    fileOk;
  int    cycles      = 0;
  // Replaced once the stimulus length is known
  int    cycleLimit  = 100000;
  int    checks      = 0;
  int    errReadVal  = 0;
  int    errIllegal  = 0;
  int    errPending  = 0;
  int    errOutputs  = 0;

  csrSupervisorUnit #(
    .NSupported (1)
  ) i_csrSupervisorUnit (
    .clk        (clk),
    .rstN       (rstN),
    .csrReq     (csrReq),
    .trap       (trap),
    .pendIrq    (pendIrq),
    .readVal    (readVal),
    .illegal    (illegal),
    .stvec      (stvec),
    .sepc       (sepc),
    .sedeleg    (sedeleg),
    .sideleg    (sideleg),
    .sstatus    (sstatus),
    .pendingIrq (pendingIrq)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock and timeout
  ////////////////////////////////////////////////////////////////////////////

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycleLimit) begin
      $display("Timeout after %0d cycles, the test sequence never finished", cycles);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////////////////////////////////////////

  task automatic loadStimulus(output bit ok);
    int fd;
    int n;
    int ch;
    string tag;
    logic [31:0] fOp, fAdr, fSrc, fStb, fEpc, fCause;
    logic [31:0] fTval, fPrev, fPend, fRead, fIll, fPendExp;
    vecT v;
    ok = 1'b0;
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %s", StimFile);
      return;
    end
    ok = 1'b1;
    n = $fscanf(fd, "%s", tag);
    while (n == 1) begin
      if (tag.getc(0) == "#") begin
        // Column description, skip to end of line
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1)
          ch = $fgetc(fd);
      end else begin
        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                    fOp, fAdr, fSrc, fStb, fEpc, fCause,
                    fTval, fPrev, fPend, fRead, fIll, fPendExp);
        if (n != 12) begin
          $display("Stimulus line %s has missing or unreadable columns", tag);
          ok = 1'b0;
        end else begin
          // Every line carries an instruction, CsrNone marks an idle slot
          v.req.valid       = 1'b1;
          v.req.op          = csrOpE'(fOp[1:0]);
          v.req.adr         = fAdr[11:0];
          v.req.src         = fSrc;
          v.trap.strobe     = fStb[0];
          v.trap.epc        = fEpc;
          v.trap.cause      = fCause;
          v.trap.tval       = fTval;
          v.trap.prevPrivS  = fPrev[0];
          v.pendIrq         = fPend[2:0];
          v.expRead         = fRead;
          v.expIllegal      = fIll[0];
          v.expPending      = fPendExp[0];
          vectors.push_back(v);
          tags.push_back(tag);
        end
      end
      if (ok)
        n = $fscanf(fd, "%s", tag);
      else
        n = 0;
    end
    $fclose(fd);
    if (vectors.size() == 0) begin
      $display("Stimulus file %s holds no vectors", StimFile);
      ok = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////////////////////////////////////////

  // One register output against its expected word
  task automatic compareRegOutput(input string name, input string what,
                                  input logic [XLEN-1:0] expVal,
                                  input logic [XLEN-1:0] actVal);
    assert (actVal === expVal) else begin
      errOutputs++;
      $display("** Error %s: %s expected %h, actual %h", name, what, expVal, actVal);
    end
  endtask

  // All register outputs are zero under reset
  task automatic checkResetState();
    compareRegOutput("reset", "stvec", '0, stvec);
    compareRegOutput("reset", "sepc", '0, sepc);
    compareRegOutput("reset", "sedeleg", '0, sedeleg);
    compareRegOutput("reset", "sideleg", '0, sideleg);
    compareRegOutput("reset", "sstatus", '0, sstatus);
  endtask

  task automatic checkOutputs(input string name, input vecT v);
    checks++;
    assert (readVal === v.expRead) else begin
      errReadVal++;
      $display("** Error %s: readVal expected %h, actual %h", name, v.expRead, readVal);
    end
    assert (illegal === v.expIllegal) else begin
      errIllegal++;
      $display("** Error %s: illegal expected %b, actual %b", name, v.expIllegal, illegal);
    end
    assert (pendingIrq === v.expPending) else begin
      errPending++;
      $display("** Error %s: pendingIrq expected %b, actual %b",
               name, v.expPending, pendingIrq);
    end
    // A register output holds what the read mux shows for its address
    case (v.req.adr)
      AdrSstatus: compareRegOutput(name, "sstatus", v.expRead, sstatus);
      AdrStvec:   compareRegOutput(name, "stvec", v.expRead, stvec);
      AdrSepc:    compareRegOutput(name, "sepc", v.expRead, sepc);
      AdrSedeleg: compareRegOutput(name, "sedeleg", v.expRead, sedeleg);
      AdrSideleg: compareRegOutput(name, "sideleg", v.expRead, sideleg);
      default: ;
    endcase
  endtask

  // Drive shortly after the edge, sample just before the next one
  task automatic applyVector(input int idx);
    vecT v;
    v = vectors[idx];
    @(posedge clk);
    #2;
    csrReq  = v.req;
    trap    = v.trap;
    pendIrq = v.pendIrq;
    #36;
    checkOutputs(tags[idx], v);
  endtask

  initial begin
    rstN    = 1'b0;
    csrReq  = '0;
    trap    = '0;
    pendIrq = '0;
    loadStimulus(fileOk);
    if (!fileOk) begin
      $display("Stimulus could not be loaded, no vectors were run");
      $display("Something failed");
      $finish;
    end else begin
      // Reset, one cycle per line, plus slack
      cycleLimit = vectors.size() + ResetCycles + 20;
      repeat (ResetCycles) @(posedge clk);
      #2;
      checkResetState();
      rstN = 1'b1;
      for (int i = 0; i < vectors.size(); i++)
        applyVector(i);
      @(posedge clk);
      #2;
      csrReq  = '0;
      trap    = '0;
      pendIrq = '0;
      $display("Checked %0d lines, errors readVal %0d, illegal %0d, pendingIrq %0d, outputs %0d",
               checks, errReadVal, errIllegal, errPending, errOutputs);
      if (errReadVal + errIllegal + errPending + errOutputs == 0) begin
        $display("Everything OK");
      end else begin
        $display("Something failed");
      end
      $finish;
    end
  end

endmodule

//--- testbench/csrSupervisorUnit_props.sv
`timescale 1ns/1ns

module csrSupervisorUnitProps import csrPkg::*; (
  input logic            clk,
  input logic            rstN,
  input logic            illegal,
  input logic            wrEn,
  input trapT            trap,
  input logic [XLEN-1:0] sepc,
  input logic [XLEN-1:0] sstatus
);

  // Illegal access never reaches a register
  noWriteOnIllegal: assert property (@(posedge clk) disable iff (!rstN)
    !(illegal && wrEn))
    else $error("illegal and wrEn are high in the same cycle");

  // Trap loads sepc at the following edge
  trapLoadsSepc: assert property (@(posedge clk) disable iff (!rstN)
    trap.strobe |=> (sepc == $past(trap.epc)))
    else $error("sepc does not hold the trap epc after a trap strobe");

  // Leaving reset with a clean sstatus
  statusClearAfterReset: assert property (@(posedge clk)
    $rose(rstN) |-> (sstatus == '0))
    else $error("sstatus is not zero when reset is released");

endmodule

bind csrSupervisorUnit csrSupervisorUnitProps i_csrSupervisorUnitProps (
  .clk     (clk),
  .rstN    (rstN),
  .illegal (illegal),
  .wrEn    (wrEn),
  .trap    (trap),
  .sepc    (sepc),
  .sstatus (sstatus)
);

//--- testbench/csr_stimulus.txt
# tag op(0 none,1 rw,2 rs,3 rc) adr src | trap: strobe epc cause tval prevPrivS | pendIrq
# expected: readVal illegal pendingIrq (all columns hex)
rw_scratch      1 140 DEADBEEF 0 00000000 00000000 00000000 0 0 00000000 0 0
rs_scratch      2 140 00000F00 0 00000000 00000000 00000000 0 0 DEADBEEF 0 0
rc_scratch      3 140 FFFF0000 0 00000000 00000000 00000000 0 0 DEADBFEF 0 0
rs_zero         2 140 00000000 0 00000000 00000000 00000000 0 0 0000BFEF 0 0
rc_zero         3 140 00000000 0 00000000 00000000 00000000 0 0 0000BFEF 0 0
none_scratch    0 140 12345678 0 00000000 00000000 00000000 0 0 0000BFEF 0 0
rd_scratch      2 140 00000000 0 00000000 00000000 00000000 0 0 0000BFEF 0 0
rw_status       1 100 FFFFFFFF 0 00000000 00000000 00000000 0 0 00000000 0 0
rd_status       2 100 00000000 0 00000000 00000000 00000000 0 0 000C0122 0 0
rw_counteren    1 106 FFFFFFFF 0 00000000 00000000 00000000 0 0 00000000 0 0
rw_sedeleg      1 102 FFFFFFFF 0 00000000 00000000 00000000 0 0 00000000 0 0
rd_counteren    2 106 00000000 0 00000000 00000000 00000000 0 0 FFFFFFFD 0 0
rd_sedeleg      2 102 00000000 0 00000000 00000000 00000000 0 0 FFFFF1FF 0 0
ill_300         1 300 55555555 0 00000000 00000000 00000000 0 0 00000000 1 0
ill_7ff         2 7FF FFFFFFFF 0 00000000 00000000 00000000 0 0 00000000 1 0
rd_scratch_ill  2 140 00000000 0 00000000 00000000 00000000 0 0 0000BFEF 0 0
rc_status       3 100 00000120 0 00000000 00000000 00000000 0 0 000C0122 0 0
trap_plain      2 100 00000000 1 80001000 0000000D 00000BAD 0 0 000C0002 0 0
rd_status_trap  2 100 00000000 0 00000000 00000000 00000000 0 0 000C0020 0 0
rd_sepc         2 141 00000000 0 00000000 00000000 00000000 0 0 80001000 0 0
rd_scause       2 142 00000000 0 00000000 00000000 00000000 0 0 0000000D 0 0
rd_stval        2 143 00000000 0 00000000 00000000 00000000 0 0 00000BAD 0 0
trap_vs_write   1 141 11111111 1 80002004 00000002 00000000 1 0 80001000 0 0
rd_sepc_win     2 141 00000000 0 00000000 00000000 00000000 0 0 80002004 0 0
rd_status_spp   2 100 00000000 0 00000000 00000000 00000000 0 0 000C0100 0 0
rw_sie          1 104 FFFFFFFF 0 00000000 00000000 00000000 0 2 00000000 0 0
rd_sip          2 144 00000000 0 00000000 00000000 00000000 0 2 00000020 0 1
rd_sie          2 104 00000000 0 00000000 00000000 00000000 0 2 00000222 0 1
clr_sie         3 104 FFFFFFFF 0 00000000 00000000 00000000 0 2 00000222 0 1
rd_sip_off      2 144 00000000 0 00000000 00000000 00000000 0 2 00000020 0 0
